//--- logic/rv32_isa_pkg.sv
package rv32_isa_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  // major opcodes of the kept instruction groups
  localparam logic [6:0] op_lui     = 7'b01_101_11;
  localparam logic [6:0] op_reg_imm = 7'b00_100_11;
  localparam logic [6:0] op_reg_reg = 7'b01_100_11;
  localparam logic [6:0] op_branch  = 7'b11_000_11;
  localparam logic [6:0] op_environ = 7'b11_100_11;

  // funct3 for register-immediate and register-register ops
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // alt selects sub and arithmetic right shift
  localparam logic [6:0] f7_base = 7'b000_0000;
  localparam logic [6:0] f7_alt  = 7'b010_0000;

  // R-type layout with msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } insn_fields_t;

  localparam word_t pc_step = 32'd4;

endpackage

//--- logic/rv32_core_pkg.sv
package rv32_core_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    // lui passes the shifted immediate straight through
    alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
  } branch_cond_t;

  typedef struct packed {
    alu_op_t                 alu_op;
    branch_cond_t            branch_cond;
    logic                    use_imm;
    rv32_isa_pkg::reg_addr_t rs1;
    rv32_isa_pkg::reg_addr_t rs2;
    rv32_isa_pkg::reg_addr_t rd;
    logic                    rd_we;
    rv32_isa_pkg::word_t     imm;
    logic                    is_ecall;
    logic                    is_illegal;
  } decoded_t;

  // architectural effect of one retired instruction
  typedef struct packed {
    rv32_isa_pkg::word_t     pc;
    rv32_isa_pkg::word_t     insn;
    rv32_isa_pkg::reg_addr_t rd;
    logic                    rd_we;
    rv32_isa_pkg::word_t     rd_data;
  } retire_t;

endpackage

//--- logic/rv32_decoder.sv
`timescale 1ns/1ps

module rv32_decoder (
  input  rv32_isa_pkg::word_t     insn,
  output rv32_core_pkg::decoded_t decoded
);

  rv32_isa_pkg::insn_fields_t fields;
  rv32_isa_pkg::word_t imm_i;
  rv32_isa_pkg::word_t imm_b;
  rv32_isa_pkg::word_t imm_u;
  logic f7_is_base;
  logic f7_is_alt;

  // base op for each funct3, shared by the immediate and register groups
  function automatic rv32_core_pkg::alu_op_t base_alu_op(input logic [2:0] funct3);
    case (funct3)
      rv32_isa_pkg::f3_add:  return rv32_core_pkg::alu_add;
      rv32_isa_pkg::f3_sll:  return rv32_core_pkg::alu_sll;
      rv32_isa_pkg::f3_slt:  return rv32_core_pkg::alu_slt;
      rv32_isa_pkg::f3_sltu: return rv32_core_pkg::alu_sltu;
      rv32_isa_pkg::f3_xor:  return rv32_core_pkg::alu_xor;
      rv32_isa_pkg::f3_sr:   return rv32_core_pkg::alu_srl;
      rv32_isa_pkg::f3_or:   return rv32_core_pkg::alu_or;
      default:               return rv32_core_pkg::alu_and;
    endcase
  endfunction

  assign fields = insn;

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  // B immediate is scrambled across funct7 and rd with bit 0 implied zero
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign f7_is_base = fields.funct7 == rv32_isa_pkg::f7_base;
  assign f7_is_alt  = fields.funct7 == rv32_isa_pkg::f7_alt;

  always_comb begin
    decoded             = '0;
    decoded.alu_op      = base_alu_op(fields.funct3);
    decoded.branch_cond = rv32_core_pkg::br_none;
    decoded.rs1         = fields.rs1;
    decoded.rs2         = fields.rs2;
    decoded.rd          = fields.rd;

    case (fields.opcode)
      rv32_isa_pkg::op_lui: begin
        decoded.alu_op  = rv32_core_pkg::alu_pass_b;
        decoded.use_imm = 1'b1;
        decoded.imm     = imm_u;
        decoded.rd_we   = 1'b1;
      end
      rv32_isa_pkg::op_reg_imm: begin
        decoded.use_imm = 1'b1;
        decoded.imm     = imm_i;
        decoded.rd_we   = 1'b1;
        // shifts keep funct7 in the upper immediate bits
        if (fields.funct3 == rv32_isa_pkg::f3_sr && f7_is_alt) begin
          decoded.alu_op = rv32_core_pkg::alu_sra;
        end else if ((fields.funct3 == rv32_isa_pkg::f3_sll ||
                       fields.funct3 == rv32_isa_pkg::f3_sr) && !f7_is_base) begin
          decoded.is_illegal = 1'b1;
        end
      end
      rv32_isa_pkg::op_reg_reg: begin
        decoded.rd_we = 1'b1;
        if (f7_is_alt && fields.funct3 == rv32_isa_pkg::f3_add) begin
          decoded.alu_op = rv32_core_pkg::alu_sub;
        end else if (f7_is_alt && fields.funct3 == rv32_isa_pkg::f3_sr) begin
          decoded.alu_op = rv32_core_pkg::alu_sra;
        end else if (!f7_is_base) begin
          decoded.is_illegal = 1'b1;
        end
      end
      rv32_isa_pkg::op_branch: begin
        decoded.imm = imm_b;
        case (fields.funct3)
          rv32_isa_pkg::f3_beq:  decoded.branch_cond = rv32_core_pkg::br_eq;
          rv32_isa_pkg::f3_bne:  decoded.branch_cond = rv32_core_pkg::br_ne;
          rv32_isa_pkg::f3_blt:  decoded.branch_cond = rv32_core_pkg::br_lt;
          rv32_isa_pkg::f3_bge:  decoded.branch_cond = rv32_core_pkg::br_ge;
          rv32_isa_pkg::f3_bltu: decoded.branch_cond = rv32_core_pkg::br_ltu;
          rv32_isa_pkg::f3_bgeu: decoded.branch_cond = rv32_core_pkg::br_geu;
          default:               decoded.is_illegal  = 1'b1;
        endcase
      end
      rv32_isa_pkg::op_environ: begin
        // only ecall is kept so everything above the opcode must be zero
        decoded.is_ecall   = insn[31:7] == 25'd0;
        decoded.is_illegal = insn[31:7] != 25'd0;
      end
      default: begin
        decoded.is_illegal = 1'b1;
      end
    endcase

    if (decoded.is_illegal) begin
      decoded.rd_we = 1'b0;
    end
  end

endmodule

//--- logic/rv32_reg_file.sv
`timescale 1ns/1ps

module rv32_reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  rv32_isa_pkg::reg_addr_t rs1,
  input  rv32_isa_pkg::reg_addr_t rs2,
  output rv32_isa_pkg::word_t     rs1_data,
  output rv32_isa_pkg::word_t     rs2_data,
  input  rv32_isa_pkg::reg_addr_t rd,
  input  rv32_isa_pkg::word_t     rd_data,
  input  logic                    rd_we
);

  // x0 has no storage
  rv32_isa_pkg::word_t regs [1:31];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- logic/rv32_alu.sv
`timescale 1ns/1ps

module rv32_alu (
  input  rv32_core_pkg::decoded_t decoded,
  input  rv32_isa_pkg::word_t     rs1_data,
  input  rv32_isa_pkg::word_t     rs2_data,
  output rv32_isa_pkg::word_t     result,
  output logic                    branch_taken
);

  rv32_isa_pkg::word_t op_b;
  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;
  logic br_eq;
  logic br_lt;
  logic br_ltu;

  assign op_b  = decoded.use_imm ? decoded.imm : rs2_data;
  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(rs1_data) < $signed(op_b);
  assign lt_unsigned = rs1_data < op_b;

  always_comb begin
    case (decoded.alu_op)
      rv32_core_pkg::alu_add:  result = rs1_data + op_b;
      rv32_core_pkg::alu_sub:  result = rs1_data - op_b;
      rv32_core_pkg::alu_sll:  result = rs1_data << shamt;
      rv32_core_pkg::alu_slt:  result = {31'b0, lt_signed};
      rv32_core_pkg::alu_sltu: result = {31'b0, lt_unsigned};
      rv32_core_pkg::alu_xor:  result = rs1_data ^ op_b;
      rv32_core_pkg::alu_srl:  result = rs1_data >> shamt;
      rv32_core_pkg::alu_sra:  result = $signed(rs1_data) >>> shamt;
      rv32_core_pkg::alu_or:   result = rs1_data | op_b;
      rv32_core_pkg::alu_and:  result = rs1_data & op_b;
      default:                 result = op_b;
    endcase
  end

  // branches always compare the two registers and never the immediate
  assign br_eq  = rs1_data == rs2_data;
  assign br_lt  = $signed(rs1_data) < $signed(rs2_data);
  assign br_ltu = rs1_data < rs2_data;

  always_comb begin
    case (decoded.branch_cond)
      rv32_core_pkg::br_eq:  branch_taken = br_eq;
      rv32_core_pkg::br_ne:  branch_taken = !br_eq;
      rv32_core_pkg::br_lt:  branch_taken = br_lt;
      rv32_core_pkg::br_ge:  branch_taken = !br_lt;
      rv32_core_pkg::br_ltu: branch_taken = br_ltu;
      rv32_core_pkg::br_geu: branch_taken = !br_ltu;
      default:               branch_taken = 1'b0;
    endcase
  end

endmodule

//--- logic/rv32_pc_unit.sv
`timescale 1ns/1ps

module rv32_pc_unit (
  input  logic                clk,
  input  logic                rst,
  input  rv32_isa_pkg::word_t imm,
  input  logic                branch_taken,
  input  logic                is_ecall,
  input  logic                is_illegal,
  output rv32_isa_pkg::word_t pc,
  output logic                halt,
  output logic                illegal
);

  rv32_isa_pkg::word_t pc_next;
  logic stop;

  // ecall or a bad word stops the core on this cycle
  assign stop = is_ecall || is_illegal;

  always_comb begin
    if (halt || stop) begin
      pc_next = pc;
    end else if (branch_taken) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + rv32_isa_pkg::pc_step;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= '0;
      halt    <= 1'b0;
      illegal <= 1'b0;
    end else begin
      pc <= pc_next;
      // the first stop latches its cause until reset
      if (!halt && stop) begin
        halt    <= 1'b1;
        illegal <= is_illegal;
      end
    end
  end

endmodule

//--- logic/rv32_core.sv
`timescale 1ns/1ps

module rv32_core (
  input  logic                   clk,
  input  logic                   rst,
  output rv32_isa_pkg::word_t    pc,
  input  rv32_isa_pkg::word_t    insn,
  output logic                   retire_valid,
  output rv32_core_pkg::retire_t retire,
  output logic                   halt,
  output logic                   illegal
);

  rv32_core_pkg::decoded_t decoded;
  rv32_isa_pkg::word_t rs1_data;
  rv32_isa_pkg::word_t rs2_data;
  rv32_isa_pkg::word_t result;
  logic branch_taken;
  logic running;
  logic rd_we;

  assign running      = !halt && !rst;
  assign rd_we        = decoded.rd_we && running;
  assign retire_valid = running && !decoded.is_ecall && !decoded.is_illegal;

  assign retire.pc      = pc;
  assign retire.insn    = insn;
  assign retire.rd      = decoded.rd;
  assign retire.rd_we   = rd_we;
  assign retire.rd_data = result;

  rv32_decoder i_decoder (
    .insn    (insn),
    .decoded (decoded)
  );

  rv32_reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (decoded.rs1),
    .rs2      (decoded.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (decoded.rd),
    .rd_data  (result),
    .rd_we    (rd_we)
  );

  rv32_alu i_alu (
    .decoded      (decoded),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (result),
    .branch_taken (branch_taken)
  );

  rv32_pc_unit i_pc_unit (
    .clk          (clk),
    .rst          (rst),
    .imm          (decoded.imm),
    .branch_taken (branch_taken),
    .is_ecall     (decoded.is_ecall),
    .is_illegal   (decoded.is_illegal),
    .pc           (pc),
    .halt         (halt),
    .illegal      (illegal)
  );

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // power-on reset for three cycles
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

//--- dv/rv32_core_assertions.sv
`timescale 1ns/1ps

module rv32_core_assertions (
  input logic                   clk,
  input logic                   rst,
  input rv32_isa_pkg::word_t    pc,
  input rv32_isa_pkg::word_t    insn,
  input logic                   retire_valid,
  input rv32_core_pkg::retire_t retire,
  input logic                   halt,
  input logic                   illegal
);

  localparam rv32_isa_pkg::word_t ecall_word = 32'h0000_0073;

  int fails = 0;
  rv32_isa_pkg::word_t shadow [0:31];
  rv32_isa_pkg::word_t a;
  rv32_isa_pkg::word_t b;
  rv32_isa_pkg::word_t imm_b;
  rv32_isa_pkg::word_t exp_next;
  logic taken;

  // register view rebuilt from the retire port
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        shadow[i] <= '0;
      end
    end else if (retire_valid && retire.rd_we && retire.rd != 5'd0) begin
      shadow[retire.rd] <= retire.rd_data;
    end
  end

  always_comb begin
    a = shadow[insn[19:15]];
    b = shadow[insn[24:20]];
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    case (insn[14:12])
      3'd0: taken = a == b;
      3'd1: taken = a != b;
      3'd4: taken = $signed(a) < $signed(b);
      3'd5: taken = $signed(a) >= $signed(b);
      3'd6: taken = a < b;
      3'd7: taken = a >= b;
      default: taken = 1'b0;
    endcase
    if (insn[6:0] == rv32_isa_pkg::op_branch && taken) begin
      exp_next = retire.pc + imm_b;
    end else begin
      exp_next = retire.pc + 32'd4;
    end
  end

  a_reset_quiet: assert property (@(posedge clk) rst |-> !retire_valid)
    else begin $error("retire_valid high during reset"); fails++; end

  a_reset_state: assert property (@(posedge clk) rst && $past(rst) |-> !halt && !illegal)
    else begin $error("halt or illegal high during reset"); fails++; end

  a_first_pc: assert property (@(posedge clk) $fell(rst) |-> pc == 32'd0)
    else begin $error("pc not zero after reset"); fails++; end

  a_next_pc: assert property (@(posedge clk) disable iff (rst)
    retire_valid |=> pc == $past(exp_next))
    else begin $error("wrong next pc"); fails++; end

  a_ecall_halt: assert property (@(posedge clk) disable iff (rst)
    !halt && insn == ecall_word |-> !retire_valid ##1 (halt && !illegal))
    else begin $error("ecall did not halt cleanly"); fails++; end

  a_illegal_halt: assert property (@(posedge clk) disable iff (rst)
    !halt && !retire_valid && insn != ecall_word |=> halt && illegal)
    else begin $error("illegal word did not halt and flag"); fails++; end

  a_halt_hold: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt && $stable(pc) && !retire_valid)
    else begin $error("core moved while halted"); fails++; end

  a_illegal_hold: assert property (@(posedge clk) disable iff (rst) illegal |=> illegal)
    else begin $error("illegal flag dropped before reset"); fails++; end

endmodule

//--- dv/tb_rv32_core.sv
`timescale 1ns/1ps

module tb_rv32_core;

  logic clk;
  logic por;
  logic rst_extra;
  logic rst;
  rv32_isa_pkg::word_t pc;
  rv32_isa_pkg::word_t insn;
  logic retire_valid;
  rv32_core_pkg::retire_t retire;
  logic halt;
  logic illegal;

  rv32_isa_pkg::word_t imem [0:255];
  rv32_isa_pkg::word_t shadow [0:31];
  rv32_isa_pkg::word_t rnd;
  rv32_isa_pkg::word_t expected;
  logic writes;
  logic [11:0] imm;
  int n = 0;
  int errors = 0;
  int limit_cycles = 0;

  assign rst  = por || rst_extra;
  assign insn = imem[pc[9:2]];

  tb_clock i_clock (.clk(clk), .rst(por));

  rv32_core i_dut (
    .clk(clk), .rst(rst), .pc(pc), .insn(insn), .retire_valid(retire_valid),
    .retire(retire), .halt(halt), .illegal(illegal)
  );

  bind rv32_core rv32_core_assertions i_assertions (
    .clk(clk), .rst(rst), .pc(pc), .insn(insn), .retire_valid(retire_valid),
    .retire(retire), .halt(halt), .illegal(illegal)
  );

  function automatic rv32_isa_pkg::word_t reg_reg_word(logic [6:0] f7, logic [4:0] rs2,
                                                       logic [4:0] rs1, logic [2:0] f3,
                                                       logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv32_isa_pkg::op_reg_reg};
  endfunction

  function automatic rv32_isa_pkg::word_t reg_imm_word(logic [11:0] i12, logic [4:0] rs1,
                                                       logic [2:0] f3, logic [4:0] rd);
    return {i12, rs1, f3, rd, rv32_isa_pkg::op_reg_imm};
  endfunction

  function automatic rv32_isa_pkg::word_t branch_word(logic [2:0] f3, logic [4:0] rs1,
                                                      logic [4:0] rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv32_isa_pkg::op_branch};
  endfunction

  // RV32I result of an ALU or LUI instruction
  function automatic rv32_isa_pkg::word_t ref_result(rv32_isa_pkg::word_t ins,
                                                     rv32_isa_pkg::word_t a,
                                                     rv32_isa_pkg::word_t b);
    rv32_isa_pkg::word_t y;
    logic [4:0] sh;
    if (ins[6:0] == rv32_isa_pkg::op_lui) return {ins[31:12], 12'd0};
    y  = (ins[6:0] == rv32_isa_pkg::op_reg_imm) ? {{20{ins[31]}}, ins[31:20]} : b;
    sh = y[4:0];
    case (ins[14:12])
      3'd0: return (ins[6:0] == rv32_isa_pkg::op_reg_reg && ins[30]) ? a - y : a + y;
      3'd1: return a << sh;
      3'd2: return {31'd0, $signed(a) < $signed(y)};
      3'd3: return {31'd0, a < y};
      3'd4: return a ^ y;
      3'd5: begin
        if (ins[30]) return $signed(a) >>> sh;
        return a >> sh;
      end
      3'd6: return a | y;
      default: return a & y;
    endcase
  endfunction

  task automatic emit(input rv32_isa_pkg::word_t w);
    imem[n] = w;
    n++;
  endtask

  // taken pair then untaken pair that each skip one increment of x9
  task automatic add_branch(input logic [2:0] f3, input logic [4:0] t1, input logic [4:0] t2,
                            input logic [4:0] u1, input logic [4:0] u2);
    emit(branch_word(f3, t1, t2, 13'd8));
    emit(reg_imm_word(12'd1, 5'd9, 3'd0, 5'd9));
    emit(branch_word(f3, u1, u2, 13'd8));
    emit(reg_imm_word(12'd1, 5'd9, 3'd0, 5'd9));
  endtask

  always @(negedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) shadow[i] = '0;
    end else if (retire_valid) begin
      writes = retire.insn[6:0] != rv32_isa_pkg::op_branch;
      if (retire.insn !== insn) begin
        $display("** Error at %0t: retire.insn expected %h, got %h",
                 $time, insn, retire.insn);
        errors++;
      end
      if (retire.rd_we !== writes) begin
        $display("** Error at %0t: retire.rd_we expected %b, got %b",
                 $time, writes, retire.rd_we);
        errors++;
      end
      if (writes) begin
        if (retire.rd !== retire.insn[11:7]) begin
          $display("** Error at %0t: retire.rd expected %0d, got %0d",
                   $time, retire.insn[11:7], retire.rd);
          errors++;
        end
        expected = ref_result(retire.insn, shadow[retire.insn[19:15]],
                              shadow[retire.insn[24:20]]);
        if (retire.rd_data !== expected) begin
          $display("** Error at %0t: retire.rd_data expected %h, got %h",
                   $time, expected, retire.rd_data);
          errors++;
        end
        if (retire.insn[11:7] != 5'd0) shadow[retire.insn[11:7]] = expected;
      end
    end
  end

  initial begin
    wait (limit_cycles != 0);
    #(limit_cycles * 100);
    $display("timeout: core did not halt within %0d cycles", limit_cycles);
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(32'h7824));
    rst_extra = 1'b0;
    for (int i = 0; i < 256; i++) imem[i] = 32'h0000_0073;
    // x1 small and positive
    // x2 is x1 plus one and x3 is random and negative
    rnd = $urandom % 2047;
    emit(reg_imm_word(rnd[11:0], 5'd0, 3'd0, 5'd1));
    emit(reg_imm_word(12'd1, 5'd1, 3'd0, 5'd2));
    rnd = $urandom;
    emit({2'b11, rnd[17:0], 5'd3, rv32_isa_pkg::op_lui});
    rnd = $urandom;
    emit(reg_imm_word(rnd[11:0], 5'd3, 3'd0, 5'd3));
    for (int f = 0; f < 8; f++) begin
      emit(reg_reg_word(rv32_isa_pkg::f7_base, 5'd1, 5'd3, 3'(f), 5'(4 + f)));
    end
    emit(reg_reg_word(rv32_isa_pkg::f7_alt, 5'd1, 5'd3, rv32_isa_pkg::f3_add, 5'd12));
    emit(reg_reg_word(rv32_isa_pkg::f7_alt, 5'd2, 5'd3, rv32_isa_pkg::f3_sr, 5'd13));
    for (int f = 1; f < 8; f++) begin
      rnd = $urandom;
      imm = (f == 1 || f == 5) ? {7'd0, rnd[4:0]} : rnd[11:0];
      emit(reg_imm_word(imm, 5'd3, 3'(f), 5'(13 + f)));
    end
    rnd = $urandom;
    emit(reg_imm_word({rv32_isa_pkg::f7_alt, 1'b1, rnd[3:0]}, 5'd3, rv32_isa_pkg::f3_sr,
                      5'd21));
    emit(reg_imm_word(12'd5, 5'd1, 3'd0, 5'd0));
    emit(reg_reg_word(rv32_isa_pkg::f7_base, 5'd1, 5'd0, rv32_isa_pkg::f3_add, 5'd22));
    add_branch(rv32_isa_pkg::f3_beq, 5'd1, 5'd1, 5'd1, 5'd2);
    add_branch(rv32_isa_pkg::f3_bne, 5'd1, 5'd2, 5'd1, 5'd1);
    add_branch(rv32_isa_pkg::f3_blt, 5'd3, 5'd1, 5'd1, 5'd3);
    add_branch(rv32_isa_pkg::f3_bge, 5'd1, 5'd3, 5'd3, 5'd1);
    add_branch(rv32_isa_pkg::f3_bltu, 5'd1, 5'd3, 5'd3, 5'd1);
    add_branch(rv32_isa_pkg::f3_bgeu, 5'd3, 5'd1, 5'd1, 5'd3);
    // both phases with their reset and 20 cycles of slack each
    limit_cycles = (n + 20 + 3) + (1 + 20 + 3);

    wait (rst === 1'b0);
    while (!halt) begin
      @(posedge clk);
      #1;
    end
    imem[0] = 32'hffff_ffff;
    rst_extra = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst_extra = 1'b0;
    while (!halt) begin
      @(posedge clk);
      #1;
    end
    repeat (2) @(posedge clk);

    $display("result check errors: %0d, assertion failures: %0d",
             errors, i_dut.i_assertions.fails);
    if (errors == 0 && i_dut.i_assertions.fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- files.f
logic/rv32_isa_pkg.sv
logic/rv32_core_pkg.sv
logic/rv32_decoder.sv
logic/rv32_reg_file.sv
logic/rv32_alu.sv
logic/rv32_pc_unit.sv
logic/rv32_core.sv
dv/tb_clock.sv
dv/rv32_core_assertions.sv
dv/tb_rv32_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_rv32_core -f files.f -o sim_rv32
output=$(./obj_dir/sim_rv32 +verilator+error+limit+1000)
echo "$output"

if grep -qx "All tests passed!" <<< "$output"; then
  exit 0
fi
exit 1
